//--- logic/llm_int_pkg.sv
package llm_int_pkg;

    // element widths.
    localparam int DATA_W      = 16;
    localparam int QUANT_W     = 8;
    localparam int QUANT_SHIFT = DATA_W - QUANT_W; // drop the low byte.

    // layer shape.
    localparam int VEC_LEN = 4;
    localparam int OUT_LEN = 4;
    localparam int ROW_W   = $clog2(OUT_LEN);

    // anything with a larger magnitude takes the full-precision path.
    localparam int OUTLIER_THRESHOLD = 1024;

    // accumulators, sized for VEC_LEN products without overflow.
    localparam int HIGH_ACC_W = 2 * DATA_W + $clog2(VEC_LEN);
    localparam int LOW_ACC_W  = 2 * QUANT_W + $clog2(VEC_LEN);

    // scale factors between the two paths and the output.
    localparam int LOW_SCALE_SHIFT = 2 * QUANT_SHIFT;
    localparam int OUT_SHIFT       = 16;

    typedef logic signed [DATA_W-1:0]     data_t;
    typedef logic signed [QUANT_W-1:0]    quant_t;
    typedef logic signed [HIGH_ACC_W-1:0] high_acc_t;
    typedef logic signed [LOW_ACC_W-1:0]  low_acc_t;

endpackage

//--- logic/weight_store.sv
module weight_store (
    input  logic                          clk,
    input  logic                          reset,

    // row write port.
    input  logic                          weight_valid,
    output logic                          weight_ready,
    input  logic [llm_int_pkg::ROW_W-1:0] weight_row,
    input  llm_int_pkg::data_t            weight_data [llm_int_pkg::VEC_LEN-1:0],

    input  logic                          pipe_busy, // some stage still holds a vector.

    output llm_int_pkg::data_t
        full_weights [llm_int_pkg::OUT_LEN-1:0][llm_int_pkg::VEC_LEN-1:0],
    output llm_int_pkg::quant_t
        quant_weights [llm_int_pkg::OUT_LEN-1:0][llm_int_pkg::VEC_LEN-1:0]
);
    import llm_int_pkg::*;

    logic row_write;

    // weights stay frozen while anything is in flight.
    assign weight_ready = !pipe_busy;
    assign row_write    = weight_valid && weight_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < OUT_LEN; r++) begin
                for (int c = 0; c < VEC_LEN; c++) begin
                    full_weights[r][c]  <= '0;
                    quant_weights[r][c] <= '0;
                end
            end
        end else if (row_write) begin
            for (int c = 0; c < VEC_LEN; c++) begin
                full_weights[weight_row][c] <= weight_data[c];
                // truncating quantization, upper byte kept.
                quant_weights[weight_row][c] <= quant_t'(weight_data[c] >>> QUANT_SHIFT);
            end
        end
    end

endmodule

//--- logic/outlier_scatter.sv
module outlier_scatter (
    input  logic                clk,
    input  logic                reset,

    // activation input.
    input  logic                in_valid,
    output logic                in_ready,
    input  llm_int_pkg::data_t  in_data [llm_int_pkg::VEC_LEN-1:0],

    // split vectors toward the two dot-product paths.
    output logic                out_valid,
    input  logic                out_ready,
    output llm_int_pkg::data_t  high_vec [llm_int_pkg::VEC_LEN-1:0],
    output llm_int_pkg::quant_t low_vec [llm_int_pkg::VEC_LEN-1:0]
);
    import llm_int_pkg::*;

    logic [VEC_LEN-1:0] is_outlier;
    data_t              high_next [VEC_LEN-1:0];
    quant_t             low_next [VEC_LEN-1:0];
    logic               accept;

    // magnitude test, both signs. exactly at the threshold is an inlier.
    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            is_outlier[i] = (in_data[i] > OUTLIER_THRESHOLD) ||
                            (in_data[i] < -OUTLIER_THRESHOLD);
        end
    end

    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            if (is_outlier[i]) begin
                high_next[i] = in_data[i];
                low_next[i]  = '0; // slot removed from the int8 path.
            end else begin
                high_next[i] = '0;
                low_next[i]  = quant_t'(in_data[i] >>> QUANT_SHIFT);
            end
        end
    end

    // stage register, free when empty or draining.
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < VEC_LEN; i++) begin
                high_vec[i] <= high_next[i];
                low_vec[i]  <= low_next[i];
            end
        end
    end

endmodule

//--- logic/mixed_dot.sv
module mixed_dot #(
    parameter type elem_t = llm_int_pkg::data_t,
    parameter type acc_t  = llm_int_pkg::high_acc_t
) (
    input  logic  clk,
    input  logic  reset,

    // operand vector from the scatter stage.
    input  logic  in_valid,
    output logic  in_ready,
    input  elem_t vec [llm_int_pkg::VEC_LEN-1:0],

    // matrix held steady by the weight store.
    input  elem_t weights [llm_int_pkg::OUT_LEN-1:0][llm_int_pkg::VEC_LEN-1:0],

    output logic  out_valid,
    input  logic  out_ready,
    output acc_t  sums [llm_int_pkg::OUT_LEN-1:0]
);
    import llm_int_pkg::*;

    acc_t dot [OUT_LEN-1:0];
    logic accept;

    // one row per output, operands widened before the multiply.
    always_comb begin
        for (int r = 0; r < OUT_LEN; r++) begin
            dot[r] = '0;
            for (int c = 0; c < VEC_LEN; c++) begin
                dot[r] = dot[r] + acc_t'(vec[c]) * acc_t'(weights[r][c]);
            end
        end
    end

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int r = 0; r < OUT_LEN; r++) begin
                sums[r] <= dot[r];
            end
        end
    end

endmodule

//--- logic/outlier_gather.sv
module outlier_gather (
    input  logic                   clk,
    input  logic                   reset,

    // paired sums, one per output row.
    input  logic                   in_valid,
    output logic                   in_ready,
    input  llm_int_pkg::high_acc_t high_sums [llm_int_pkg::OUT_LEN-1:0],
    input  llm_int_pkg::low_acc_t  low_sums [llm_int_pkg::OUT_LEN-1:0],

    output logic                   out_valid,
    input  logic                   out_ready,
    output llm_int_pkg::data_t     out_data [llm_int_pkg::OUT_LEN-1:0]
);
    import llm_int_pkg::*;

    // one guard bit above the high accumulator.
    logic signed [HIGH_ACC_W:0] low_wide [OUT_LEN-1:0];
    logic signed [HIGH_ACC_W:0] total [OUT_LEN-1:0];
    logic signed [HIGH_ACC_W:0] scaled [OUT_LEN-1:0];
    data_t                      sat [OUT_LEN-1:0];
    logic                       accept;

    always_comb begin
        for (int r = 0; r < OUT_LEN; r++) begin
            low_wide[r] = low_sums[r]; // sign extended.
            total[r]    = (low_wide[r] <<< LOW_SCALE_SHIFT) + high_sums[r];
            scaled[r]   = total[r] >>> OUT_SHIFT;

            // clamp to the 16-bit signed range.
            if (scaled[r] > (2 ** (DATA_W - 1)) - 1) begin
                sat[r] = {1'b0, {(DATA_W - 1){1'b1}}};
            end else if (scaled[r] < -(2 ** (DATA_W - 1))) begin
                sat[r] = {1'b1, {(DATA_W - 1){1'b0}}};
            end else begin
                sat[r] = data_t'(scaled[r]);
            end
        end
    end

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int r = 0; r < OUT_LEN; r++) begin
                out_data[r] <= sat[r];
            end
        end
    end

endmodule

//--- logic/llm_int_top.sv
module llm_int_top (
    input  logic                          clk,
    input  logic                          reset,

    // weight rows, accepted only while the pipeline is empty.
    input  logic                          weight_valid,
    output logic                          weight_ready,
    input  logic [llm_int_pkg::ROW_W-1:0] weight_row,
    input  llm_int_pkg::data_t            weight_data [llm_int_pkg::VEC_LEN-1:0],

    // activation vectors.
    input  logic                          in_valid,
    output logic                          in_ready,
    input  llm_int_pkg::data_t            in_data [llm_int_pkg::VEC_LEN-1:0],

    // layer outputs.
    output logic                          out_valid,
    input  logic                          out_ready,
    output llm_int_pkg::data_t            out_data [llm_int_pkg::OUT_LEN-1:0]
);
    import llm_int_pkg::*;

    data_t     full_weights [OUT_LEN-1:0][VEC_LEN-1:0];
    quant_t    quant_weights [OUT_LEN-1:0][VEC_LEN-1:0];

    logic      scatter_valid;
    data_t     high_vec [VEC_LEN-1:0];
    quant_t    low_vec [VEC_LEN-1:0];

    // path handshake, taken from the high instance.
    logic      path_ready;
    logic      dot_valid;
    logic      dot_ready;
    high_acc_t high_sums [OUT_LEN-1:0];
    low_acc_t  low_sums [OUT_LEN-1:0];

    logic      pipe_busy;

    assign pipe_busy = scatter_valid || dot_valid || out_valid;

    weight_store weight_store_i (
        .clk           (clk),
        .reset         (reset),
        .weight_valid  (weight_valid),
        .weight_ready  (weight_ready),
        .weight_row    (weight_row),
        .weight_data   (weight_data),
        .pipe_busy     (pipe_busy),
        .full_weights  (full_weights),
        .quant_weights (quant_weights)
    );

    outlier_scatter scatter_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (scatter_valid),
        .out_ready (path_ready),
        .high_vec  (high_vec),
        .low_vec   (low_vec)
    );

    mixed_dot #(
        .elem_t (data_t),
        .acc_t  (high_acc_t)
    ) high_dot_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (scatter_valid),
        .in_ready  (path_ready),
        .vec       (high_vec),
        .weights   (full_weights),
        .out_valid (dot_valid),
        .out_ready (dot_ready),
        .sums      (high_sums)
    );

    // runs in lockstep with high_dot_i, so its handshake outputs are not needed.
    mixed_dot #(
        .elem_t (quant_t),
        .acc_t  (low_acc_t)
    ) low_dot_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (scatter_valid),
        .in_ready  (),
        .vec       (low_vec),
        .weights   (quant_weights),
        .out_valid (),
        .out_ready (dot_ready),
        .sums      (low_sums)
    );

    outlier_gather gather_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dot_valid),
        .in_ready  (dot_ready),
        .high_sums (high_sums),
        .low_sums  (low_sums),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

//--- verif/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 10ns; // 20 ns clock.

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset held for two rising edges.
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- verif/llm_int_tb.sv
module llm_int_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import llm_int_pkg::*;

    localparam int  NUM_VECTORS = 20 + 20 + 200 + 20 + 100 + 5;
    localparam time WATCHDOG    = (NUM_VECTORS * 20 + 500) * 20ns;

    logic clk;
    logic reset;
    logic weight_valid;
    logic weight_ready;
    logic [ROW_W-1:0] weight_row;
    data_t weight_data [VEC_LEN-1:0];
    logic in_valid;
    logic in_ready;
    data_t in_data [VEC_LEN-1:0];
    logic out_valid;
    logic out_ready;
    data_t out_data [OUT_LEN-1:0];

    integer seed = 32'h8ddbf778;
    int errors = 0;
    int sent = 0;
    int received = 0;
    int sat_hits = 0;
    int cyc = 0;
    int accept_cyc = 0;
    int out_cyc = 0;
    int in_flight = 0; // vectors held in the three stage registers.
    bit bp_mode = 0;
    bit next_ready = 1;

    int model_w [OUT_LEN][VEC_LEN]; // reference copy of the weights.
    int vec [VEC_LEN];
    int exp_q [$]; // OUT_LEN entries per vector.

    clock_gen clock_gen_i (.clk(clk), .reset(reset));

    llm_int_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .weight_valid (weight_valid),
        .weight_ready (weight_ready),
        .weight_row   (weight_row),
        .weight_data  (weight_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_value(input string name, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    function automatic int quantize(input int x);
        return x >>> 8; // truncation toward minus infinity.
    endfunction

    function automatic bit is_outlier(input int x);
        return (x > 1024) || (x < -1024);
    endfunction

    // full layer output for one row from the current vec and model weights.
    function automatic int expected_row(input int r);
        longint high;
        longint low;
        longint total;
        high = 0;
        low = 0;
        for (int c = 0; c < VEC_LEN; c++) begin
            if (is_outlier(vec[c]))
                high += longint'(vec[c]) * model_w[r][c];
            else
                low += longint'(quantize(vec[c])) * quantize(model_w[r][c]);
        end
        total = ((low * 65536) + high) >>> 16;
        if (total > 32767) return 32767;
        if (total < -32768) return -32768;
        return int'(total);
    endfunction

    task automatic load_row(input int r);
        @(negedge clk);
        weight_valid = 1'b1;
        weight_row = r[ROW_W-1:0];
        for (int c = 0; c < VEC_LEN; c++) weight_data[c] = data_t'(model_w[r][c]);
        #1;
        while (!weight_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        weight_valid = 1'b0;
    endtask

    task automatic load_all_rows();
        for (int r = 0; r < OUT_LEN; r++) load_row(r);
    endtask

    // drives vec, waits for in_ready and queues the model result.
    task automatic send_vector();
        int e;
        @(negedge clk);
        in_valid = 1'b1;
        for (int c = 0; c < VEC_LEN; c++) in_data[c] = data_t'(vec[c]);
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
        end
        accept_cyc = cyc;
        for (int r = 0; r < OUT_LEN; r++) begin
            e = expected_row(r);
            exp_q.push_back(e);
        end
        sent++;
        @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    function automatic int rand_inlier();
        return $random(seed) % 1025; // -1024 to 1024.
    endfunction

    function automatic int rand_outlier();
        int m;
        m = 1025 + ($unsigned($random(seed)) % 31743);
        return ($random(seed) & 1) ? -m : m;
    endfunction

    // output side, ready driven on the falling edge and data checked before the rise.
    initial begin
        forever begin
            @(negedge clk);
            out_ready = next_ready;
            #1;
            // stage 1 stalls only with all three stages full and no drain.
            check_value("in_ready", (in_flight < 3) || out_ready, in_ready);
            check_value("weight_lock", in_flight == 0, weight_ready);
            if (out_valid && out_ready) begin
                if (exp_q.size() < OUT_LEN) begin
                    errors++;
                    $display("output appeared with no accepted input pending");
                end else begin
                    for (int r = 0; r < OUT_LEN; r++) begin
                        if (out_data[r] == 32767 || out_data[r] == -32768) sat_hits++;
                        check_value($sformatf("out_data[%0d]", r), exp_q.pop_front(),
                                    out_data[r]);
                    end
                end
                received++;
                out_cyc = cyc;
                in_flight--;
            end
            if (in_valid && in_ready) in_flight++;
            next_ready = bp_mode ? 1'($random(seed) & 1) : 1'b1; // level for the next edge.
        end
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired, the DUT stopped producing outputs");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        weight_valid = 1'b0;
        weight_row = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        for (int c = 0; c < VEC_LEN; c++) begin
            weight_data[c] = '0;
            in_data[c] = '0;
        end
        @(negedge clk);
        while (reset) @(negedge clk);
        #1;
        check_value("weight_ready_idle", 1, weight_ready);

        // inlier-only vectors use the low path.
        for (int r = 0; r < OUT_LEN; r++)
            for (int c = 0; c < VEC_LEN; c++) model_w[r][c] = int'(data_t'($random(seed)));
        load_all_rows();
        for (int n = 0; n < 20; n++) begin
            for (int c = 0; c < VEC_LEN; c++) vec[c] = rand_inlier();
            send_vector();
        end
        drain();

        for (int n = 0; n < 20; n++) begin
            for (int c = 0; c < VEC_LEN; c++) vec[c] = rand_outlier();
            send_vector();
        end
        drain();

        // mixed, with the exact threshold values.
        for (int n = 0; n < 200; n++) begin
            for (int c = 0; c < VEC_LEN; c++) begin
                case ($unsigned($random(seed)) % 4)
                    0: vec[c] = rand_inlier();
                    1: vec[c] = rand_outlier();
                    2: vec[c] = 1024;
                    default: vec[c] = -1024;
                endcase
            end
            send_vector();
        end
        drain();

        // large weights, rows of alternating sign.
        for (int r = 0; r < OUT_LEN; r++)
            for (int c = 0; c < VEC_LEN; c++) model_w[r][c] = r[0] ? -32768 : 32767;
        load_all_rows();
        sat_hits = 0;
        for (int n = 0; n < 20; n++) begin
            for (int c = 0; c < VEC_LEN; c++) vec[c] = (n[0] ? -1 : 1) * (20000 + c * 1000);
            send_vector();
        end
        drain();
        // every row of every vector here lands beyond the 16-bit range.
        check_value("saturation_count", 20 * OUT_LEN, sat_hits);

        // back-pressure with random gaps on the input.
        for (int r = 0; r < OUT_LEN; r++)
            for (int c = 0; c < VEC_LEN; c++) model_w[r][c] = int'(data_t'($random(seed)));
        load_all_rows();
        bp_mode = 1;
        for (int n = 0; n < 100; n++) begin
            repeat ($unsigned($random(seed)) % 3) @(negedge clk);
            for (int c = 0; c < VEC_LEN; c++)
                vec[c] = ($random(seed) & 1) ? rand_outlier() : rand_inlier();
            send_vector();
        end
        drain();
        bp_mode = 0;

        // isolated vectors for latency.
        for (int n = 0; n < 5; n++) begin
            for (int c = 0; c < VEC_LEN; c++) vec[c] = rand_outlier();
            send_vector();
            drain();
            check_value("latency", 3, out_cyc - accept_cyc);
        end
        #1;
        check_value("weight_ready_idle", 1, weight_ready);
        check_value("output_count", sent, received);

        $display("errors %0d, vectors sent %0d, outputs received %0d", errors, sent, received);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- llm_int.f
logic/llm_int_pkg.sv
logic/weight_store.sv
logic/outlier_scatter.sv
logic/mixed_dot.sv
logic/outlier_gather.sv
logic/llm_int_top.sv
verif/clock_gen.sv
verif/llm_int_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module llm_int_tb \
    -f llm_int.f \
    -o llm_int_sim \
    && ./obj_dir/llm_int_sim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
    && echo "simulation run: pass" \
    || { echo "simulation run: fail"; exit 1; }
